//--- can_bitlink.f
src/can_pkg.sv
src/can_apb_regs.sv
src/can_bit_timing.sv
src/can_tx_framer.sv
src/can_rx_deframer.sv
src/can_bitlink_top.sv
dv/can_bitlink_checker.sv
dv/can_bitlink_tb.sv

//--- dv/can_bitlink_checker.sv
`timescale 1ns/1ps
// Scoreboard for the CAN link that models stuffed frames on can_tx and the APB register values
module can_bitlink_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  can_pkg::apb_addr_t paddr,
    input  can_pkg::apb_data_t pwdata,
    input  can_pkg::apb_data_t prdata,
    input  logic               pready,
    input  logic               pslverr,
    input  logic               can_tx,
    output int                 err_cnt,
    output int                 check_cnt
);
    can_pkg::can_byte_t tx_q[$];     // Accepted bytes not yet on the wire
    can_pkg::can_byte_t frame_byte;  // Byte of the frame now on the wire
    can_pkg::can_byte_t rxdata_m;
    can_pkg::can_byte_t txdata_m;    // Last byte the link accepted
    logic [15:0] exp_bits;           // Stuffed bits with SOF at index 0
    int exp_len;
    int last_pos;                    // Index of the last data bit
    int clk_cnt;                     // Clocks since the SOF edge
    int bit_idx;
    int run_len;
    int due_cnt;
    logic run_bit;
    logic in_frame;
    logic tx_prev;
    logic busy_m;
    logic valid_m;
    logic ovr_m;
    logic rx_due;                    // Last data bit seen so rx_valid may rise any time now
    logic exp_err;

    // SOF plus byte MSB first with a complement after every run of STUFF_RUN
    function automatic int build_frame(input can_pkg::can_byte_t data,
                                       output logic [15:0] seq, output int data_end);
        logic [8:0] raw;
        logic last;
        int run;
        int n;
        int i;
        raw = {1'b0, data};
        last = 1'b1;
        run = 0;
        n = 0;
        seq = '0;
        data_end = 0;
        for (i = 8; i >= 0; i--) begin
            if (run == can_pkg::STUFF_RUN) begin
                seq[4'(n)] = ~last;
                last = ~last;
                run = 1;
                n++;
            end
            seq[4'(n)] = raw[4'(i)];
            run = (raw[4'(i)] == last) ? run + 1 : 1;
            last = raw[4'(i)];
            data_end = n;
            n++;
        end
        if (run == can_pkg::STUFF_RUN) begin
            seq[4'(n)] = ~last;                     // Trailing stuff bit
            n++;
        end
        return n;
    endfunction

    task compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task flag_error(input string what);
        err_cnt++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // Byte lands in RXDATA and an unread one is lost
    task commit_rx;
        ovr_m = valid_m;
        valid_m = 1'b1;
        rxdata_m = frame_byte;
        rx_due = 1'b0;
    endtask

    // Everything sampled on the falling edge away from DUT updates
    always @(negedge clk) begin
        if (!rst_n) begin
            tx_q.delete();
            err_cnt = 0;
            check_cnt = 0;
            in_frame = 1'b0;
            tx_prev = 1'b1;
            busy_m = 1'b0;
            valid_m = 1'b0;
            ovr_m = 1'b0;
            rx_due = 1'b0;
            rxdata_m = '0;
            txdata_m = '0;
            frame_byte = '0;
            clk_cnt = 0;
            due_cnt = 0;
        end else begin
            if (rx_due) begin
                due_cnt++;
                if (due_cnt >= can_pkg::BIT_CLKS) begin
                    commit_rx();
                end
            end
            if (in_frame) begin
                clk_cnt++;
                if (clk_cnt >= exp_len * can_pkg::BIT_CLKS) begin
                    compare_value("can_tx in end gap", 32'd1, 32'(can_tx));   // Every clock
                end else if (clk_cnt >= 5 && (clk_cnt - 5) % can_pkg::BIT_CLKS == 0) begin
                    bit_idx = (clk_cnt - 5) / can_pkg::BIT_CLKS;              // Mid-bit
                    compare_value("can_tx", 32'(exp_bits[4'(bit_idx)]), 32'(can_tx));
                    if (can_tx == run_bit) begin
                        run_len++;
                    end else begin
                        run_bit = can_tx;
                        run_len = 1;
                    end
                    if (run_len > can_pkg::STUFF_RUN) begin
                        flag_error("run of equal bits on can_tx is longer than the stuff limit");
                    end
                    if (bit_idx == last_pos) begin
                        rx_due = 1'b1;
                        due_cnt = 0;
                    end
                end
                if (clk_cnt == (exp_len + can_pkg::EOF_BITS) * can_pkg::BIT_CLKS) begin
                    in_frame = 1'b0;                // tx_busy has just dropped
                    busy_m = 1'b0;
                end
            end else if (tx_prev && !can_tx) begin
                // SOF edge
                if (tx_q.size() == 0) begin
                    flag_error("start of frame on can_tx without an accepted TXDATA write");
                    frame_byte = '0;
                end else begin
                    frame_byte = tx_q.pop_front();
                end
                exp_len = build_frame(frame_byte, exp_bits, last_pos);
                in_frame = 1'b1;
                clk_cnt = 0;
                run_len = 0;
                run_bit = 1'b1;
            end
            tx_prev = can_tx;

            // APB side
            exp_err = psel & penable &
                      (((paddr != can_pkg::ADDR_TXDATA) && (paddr != can_pkg::ADDR_STATUS) &&
                        (paddr != can_pkg::ADDR_RXDATA)) ||
                       (pwrite && (paddr == can_pkg::ADDR_TXDATA) && busy_m));
            compare_value("pslverr", 32'(exp_err), 32'(pslverr));
            if (psel && penable) begin
                compare_value("pready", 32'd1, 32'(pready));
                if (pwrite) begin
                    if (paddr == can_pkg::ADDR_TXDATA && !busy_m) begin
                        tx_q.push_back(pwdata[7:0]);
                        txdata_m = pwdata[7:0];
                        busy_m = 1'b1;
                    end
                end else if (paddr == can_pkg::ADDR_STATUS) begin
                    // With an unread byte the new one shows up as overrun
                    if (rx_due && (valid_m ? (prdata[2] && !ovr_m) : prdata[1])) begin
                        commit_rx();
                    end
                    compare_value("status.tx_busy", 32'(busy_m), 32'(prdata[0]));
                    if (!rx_due) begin
                        compare_value("status.rx_valid", 32'(valid_m), 32'(prdata[1]));
                        compare_value("status.overrun", 32'(ovr_m), 32'(prdata[2]));
                    end
                    compare_value("status[31:3]", 32'd0, 32'(prdata[31:3]));
                end else if (paddr == can_pkg::ADDR_TXDATA) begin
                    compare_value("txdata", {24'd0, txdata_m}, prdata);
                end else if (paddr == can_pkg::ADDR_RXDATA) begin
                    compare_value("rxdata", {24'd0, rxdata_m}, prdata);
                    valid_m = 1'b0;                 // Read clears both flags
                    ovr_m = 1'b0;
                end
            end
        end
    end

endmodule

//--- dv/can_bitlink_tb.sv
`timescale 1ns/1ps
// Testbench for the CAN bit link with APB stimulus, CAN loopback wire and LFSR payloads
module can_bitlink_tb;
    localparam int CLK_PERIOD = 20;
    localparam int FRAME_CNT = 48;   // Frames sent over all tests
    localparam int WATCHDOG_CLKS = FRAME_CNT * 30 * can_pkg::BIT_CLKS + 2000;

    logic clk;
    logic rst_n;
    logic psel;
    logic penable;
    logic pwrite;
    can_pkg::apb_addr_t paddr;
    can_pkg::apb_data_t pwdata;
    can_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;
    logic can_tx;
    logic can_rx;
    int err_cnt;
    int check_cnt;
    logic [31:0] lfsr;
    int tests_run;
    int errs_before;
    can_pkg::apb_data_t rd_data;
    can_pkg::can_byte_t pay_a;
    can_pkg::can_byte_t pay_b;

    assign can_rx = can_tx;          // Bus is a plain wire

    can_bitlink_top can_bitlink_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .can_tx  (can_tx),
        .can_rx  (can_rx)
    );

    can_bitlink_checker can_bitlink_checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .can_tx    (can_tx),
        .err_cnt   (err_cnt),
        .check_cnt (check_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output can_pkg::can_byte_t b);
        int i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);                 // One step per bit
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic idle_clocks(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // One APB transfer entered and left 2 ns after a rising edge
    task automatic bus_cycle(input logic wr, input can_pkg::apb_addr_t addr,
                             input can_pkg::apb_data_t wdata, output can_pkg::apb_data_t rdata);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;                             // Mid access cycle
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input can_pkg::apb_addr_t addr, input can_pkg::can_byte_t data);
        can_pkg::apb_data_t ignored;
        bus_cycle(1'b1, addr, {24'd0, data}, ignored);
    endtask

    task automatic read_reg(input can_pkg::apb_addr_t addr, output can_pkg::apb_data_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic wait_tx_idle;
        can_pkg::apb_data_t s;
        do read_reg(can_pkg::ADDR_STATUS, s); while (s[0]);
    endtask

    task automatic poll_rx_valid;
        can_pkg::apb_data_t s;
        do read_reg(can_pkg::ADDR_STATUS, s); while (!s[1]);
    endtask

    // Send one byte and collect it back, then STATUS shows rx_valid cleared
    task automatic loop_byte(input can_pkg::can_byte_t b);
        wait_tx_idle();
        write_reg(can_pkg::ADDR_TXDATA, b);
        poll_rx_valid();
        read_reg(can_pkg::ADDR_RXDATA, rd_data);
        read_reg(can_pkg::ADDR_STATUS, rd_data);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("Test %0d %s: %s, %0d new errors", tests_run, name,
                 (err_cnt == errs_before) ? "passed" : "failed", err_cnt - errs_before);
        errs_before = err_cnt;
    endtask

    initial begin
        int n;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsr = 32'h1671;
        tests_run = 0;
        errs_before = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        idle_clocks(3 * can_pkg::BIT_CLKS);         // Line must stay recessive
        read_reg(can_pkg::ADDR_STATUS, rd_data);
        read_reg(4'hC, rd_data);                    // Unmapped offset answers with pslverr
        report_test("reset state");

        for (n = 0; n < 40; n++) begin
            rand_byte(pay_a);
            loop_byte(pay_a);
        end
        report_test("random loopback");

        loop_byte(8'h00);
        loop_byte(8'hFF);
        loop_byte(8'hF0);
        report_test("stuffing corner bytes");

        wait_tx_idle();
        rand_byte(pay_a);
        write_reg(can_pkg::ADDR_TXDATA, pay_a);
        idle_clocks(3 * can_pkg::BIT_CLKS);
        write_reg(can_pkg::ADDR_TXDATA, ~pay_a);    // Frame still running so this one is refused
        read_reg(can_pkg::ADDR_TXDATA, rd_data);    // Still the first byte
        poll_rx_valid();
        read_reg(can_pkg::ADDR_RXDATA, rd_data);
        read_reg(can_pkg::ADDR_STATUS, rd_data);
        report_test("busy rejection");

        wait_tx_idle();
        rand_byte(pay_a);
        rand_byte(pay_b);
        write_reg(can_pkg::ADDR_TXDATA, pay_a);
        wait_tx_idle();
        write_reg(can_pkg::ADDR_TXDATA, pay_b);
        wait_tx_idle();
        read_reg(can_pkg::ADDR_STATUS, rd_data);    // Overrun expected here
        read_reg(can_pkg::ADDR_RXDATA, rd_data);
        read_reg(can_pkg::ADDR_STATUS, rd_data);
        report_test("overrun");

        // Back to back with the next write right as tx_busy drops
        wait_tx_idle();
        rand_byte(pay_a);
        rand_byte(pay_b);
        write_reg(can_pkg::ADDR_TXDATA, pay_a);
        wait_tx_idle();
        write_reg(can_pkg::ADDR_TXDATA, pay_b);
        wait_tx_idle();
        read_reg(can_pkg::ADDR_RXDATA, rd_data);
        read_reg(can_pkg::ADDR_STATUS, rd_data);
        report_test("end gap");

        idle_clocks(can_pkg::BIT_CLKS);
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Timeout: run did not finish within %0d clocks", WATCHDOG_CLKS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the CAN bit link simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module can_bitlink_tb -f can_bitlink.f --Mdir obj_dir

./obj_dir/Vcan_bitlink_tb > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- src/can_apb_regs.sv
`timescale 1ns/1ps
// APB3 register block of the CAN link with transmit byte, status flags and received byte
module can_apb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  can_pkg::apb_addr_t paddr,
    input  can_pkg::apb_data_t pwdata,
    output can_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output can_pkg::tx_req_t   tx_req,
    input  logic               tx_busy,
    input  can_pkg::rx_rsp_t   rx_rsp
);
    logic access;                  // APB access phase
    logic wr_en;
    logic rd_en;
    logic sel_tx;
    logic sel_status;
    logic sel_rx;
    logic addr_ok;
    logic wr_tx;
    logic tx_start;
    logic rd_rx;
    can_pkg::can_byte_t txdata_q;  // Last byte accepted for sending
    can_pkg::can_byte_t rxdata_q;  // Last byte off the bus
    logic rx_valid;
    logic overrun;

    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign rd_en  = access & ~pwrite;

    // Address decode
    assign sel_tx     = (paddr == can_pkg::ADDR_TXDATA);
    assign sel_status = (paddr == can_pkg::ADDR_STATUS);
    assign sel_rx     = (paddr == can_pkg::ADDR_RXDATA);
    assign addr_ok    = sel_tx | sel_status | sel_rx;

    assign wr_tx    = wr_en & sel_tx;
    assign tx_start = wr_tx & ~tx_busy;    // Dropped while a frame runs
    assign rd_rx    = rd_en & sel_rx;      // Consumes the received byte

    // Zero wait states
    assign pready  = 1'b1;
    assign pslverr = access & (~addr_ok | (wr_tx & tx_busy));

    // Start goes out in the access cycle itself
    assign tx_req = '{start: tx_start, data: pwdata[7:0]};

    // Read mux
    always_comb begin
        case (paddr)
            can_pkg::ADDR_TXDATA: prdata = {24'd0, txdata_q};
            can_pkg::ADDR_STATUS: prdata = {29'd0, overrun, rx_valid, tx_busy};
            can_pkg::ADDR_RXDATA: prdata = {24'd0, rxdata_q};
            default:              prdata = '0;
        endcase
    end

    // Transmit byte, kept for readback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txdata_q <= '0;
        end else if (tx_start) begin
            txdata_q <= pwdata[7:0];
        end
    end

    // Receive side with overrun tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxdata_q <= '0;
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else if (rx_rsp.valid) begin
            rxdata_q <= rx_rsp.data;         // New byte wins over the old one
            rx_valid <= 1'b1;
            overrun  <= rx_valid & ~rd_rx;   // Old byte lost unless read right now
        end else if (rd_rx) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end
    end

endmodule

//--- src/can_bit_timing.sv
`timescale 1ns/1ps
// CAN bit-timing FSM with input synchronizer, hard sync, resync and bit strobes
module can_bit_timing (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 can_rx,
    input  logic                 rx_idle,
    output can_pkg::bit_strobe_t strobe
);
    logic rx_meta;                  // First synchronizer flop
    logic rx_sync;                  // Safe to use from here on
    logic rx_prev;                  // For edge detection
    can_pkg::bit_seg_e seg;
    can_pkg::seg_timer_t timer;
    can_pkg::seg_timer_t seg_last;  // Last timer value of the segment
    logic edge_seen;
    logic fall;
    logic hard_sync;
    logic resync;
    logic tx_point_q;
    logic sample_q;
    logic rx_bit_q;

    assign edge_seen = rx_sync ^ rx_prev;
    assign fall      = rx_prev & ~rx_sync;                    // Recessive to dominant
    assign hard_sync = rx_idle & fall;
    assign resync    = ~rx_idle & edge_seen & (seg == can_pkg::SYNC_SEG);

    assign strobe = '{tx_point: tx_point_q, sample_point: sample_q, rx_bit: rx_bit_q};

    always_comb begin
        case (seg)
            can_pkg::SYNC_SEG:   seg_last = '0;             // One clock
            can_pkg::PROP_SEG:   seg_last = 4'd1;           // Two clocks
            can_pkg::PHASE_SEG1: seg_last = can_pkg::seg_timer_t'(can_pkg::TSEG1 - 1);
            can_pkg::PHASE_SEG2: seg_last = can_pkg::seg_timer_t'(can_pkg::TSEG2 - 1);
            default:             seg_last = '0;
        endcase
    end

    // Two-flop synchronizer, bus idles recessive
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= can_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg        <= can_pkg::SYNC_SEG;
            timer      <= '0;
            tx_point_q <= 1'b0;
            sample_q   <= 1'b0;
            rx_bit_q   <= 1'b1;
        end else begin
            tx_point_q <= 1'b0;
            sample_q   <= 1'b0;
            if (hard_sync) begin
                // Edge seen three clocks after it left the pin flop,
                // so the bit that it starts is already into PHASE_SEG1
                seg   <= can_pkg::PHASE_SEG1;
                timer <= 4'd1;
            end else if (resync) begin
                // Late edge, SYNC_SEG repeats and the timer steps back by at most SJW
                timer <= (timer > can_pkg::seg_timer_t'(can_pkg::SJW)) ?
                         timer - can_pkg::seg_timer_t'(can_pkg::SJW) : '0;
            end else if (timer < seg_last) begin
                timer <= timer + 4'd1;
            end else begin
                timer <= '0;
                case (seg)
                    can_pkg::SYNC_SEG:   seg <= can_pkg::PROP_SEG;
                    can_pkg::PROP_SEG:   seg <= can_pkg::PHASE_SEG1;
                    can_pkg::PHASE_SEG1: begin
                        seg      <= can_pkg::PHASE_SEG2;
                        sample_q <= 1'b1;
                        rx_bit_q <= rx_sync;             // Bit value for the receiver
                    end
                    can_pkg::PHASE_SEG2: begin
                        seg        <= can_pkg::SYNC_SEG;
                        tx_point_q <= 1'b1;              // Next bit may go out
                    end
                    default: seg <= can_pkg::SYNC_SEG;
                endcase
            end
        end
    end

endmodule

//--- src/can_bitlink_top.sv
`timescale 1ns/1ps
// CAN bit link top with APB registers, transmit framer, bit timing and receive deframer
module can_bitlink_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  can_pkg::apb_addr_t paddr,
    input  can_pkg::apb_data_t pwdata,
    output can_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               can_tx,
    input  logic               can_rx
);
    can_pkg::tx_req_t     tx_req;
    can_pkg::rx_rsp_t     rx_rsp;
    can_pkg::bit_strobe_t strobe;   // Shared by both directions
    logic                 tx_busy;
    logic                 rx_idle;

    can_apb_regs can_apb_regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx_req  (tx_req),
        .tx_busy (tx_busy),
        .rx_rsp  (rx_rsp)
    );

    can_tx_framer can_tx_framer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_req  (tx_req),
        .strobe  (strobe),
        .tx_busy (tx_busy),
        .can_tx  (can_tx)
    );

    can_bit_timing can_bit_timing_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .can_rx  (can_rx),
        .rx_idle (rx_idle),
        .strobe  (strobe)
    );

    can_rx_deframer can_rx_deframer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .strobe  (strobe),
        .rx_idle (rx_idle),
        .rx_rsp  (rx_rsp)
    );

endmodule

//--- src/can_pkg.sv
// CAN bit link shared package with bit-timing constants, APB register map and bus types
package can_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [7:0] can_byte_t;   // One payload byte
    typedef logic [3:0] apb_addr_t;   // Byte offset inside the register block
    typedef logic [31:0] apb_data_t;
    typedef logic [3:0] seg_timer_t;  // Clocks spent in the current segment

    // Bit timing, all counts in clocks
    localparam int TSEG1 = 5;         // PHASE_SEG1 length
    localparam int TSEG2 = 3;         // PHASE_SEG2 length
    localparam int SJW = 2;           // Largest resync step
    localparam int BIT_CLKS = 1 + 2 + TSEG1 + TSEG2;  // SYNC + PROP + both phases

    // Framing
    localparam int STUFF_RUN = 5;     // Equal bits before a complement goes in
    localparam int EOF_BITS = 7;      // Recessive bits closing a frame

    // Register offsets
    localparam apb_addr_t ADDR_TXDATA = 4'h0;
    localparam apb_addr_t ADDR_STATUS = 4'h4;
    localparam apb_addr_t ADDR_RXDATA = 4'h8;

    // Segments of one nominal bit, in bus order
    typedef enum logic [1:0] {
        SYNC_SEG,
        PROP_SEG,
        PHASE_SEG1,
        PHASE_SEG2
    } bit_seg_e;

    // Strobes from the bit-timing block, each high for one clock
    typedef struct packed {
        logic tx_point;      // First clock of SYNC_SEG
        logic sample_point;  // Right after PHASE_SEG1 ends
        logic rx_bit;        // Bus value taken at that sample point
    } bit_strobe_t;

    typedef struct packed {
        logic      start;    // One clock, byte is in data
        can_byte_t data;
    } tx_req_t;

    typedef struct packed {
        logic      valid;    // One clock per received byte
        can_byte_t data;
    } rx_rsp_t;

endpackage

//--- src/can_rx_deframer.sv
`timescale 1ns/1ps
// CAN receive deframer finding SOF, dropping stuff bits and collecting the data byte
module can_rx_deframer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  can_pkg::bit_strobe_t strobe,
    output logic                 rx_idle,
    output can_pkg::rx_rsp_t     rx_rsp
);
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_EOF
    } rx_state_e;

    rx_state_e state;
    can_pkg::can_byte_t shreg;     // Data bits, MSB arrives first
    can_pkg::can_byte_t data_q;
    logic valid_q;
    logic [3:0] bit_cnt;           // Data bits taken so far
    logic [2:0] run_cnt;
    logic last_bit;
    logic [2:0] rec_cnt;           // Recessive samples in a row after the data
    logic sample;
    logic bit_in;
    logic stuff_bit;
    logic take_bit;
    logic last_data;

    assign sample    = strobe.sample_point;
    assign bit_in    = strobe.rx_bit;
    assign stuff_bit = (run_cnt == 3'(can_pkg::STUFF_RUN));   // This bit is a stuff bit
    assign take_bit  = sample & (state == RX_DATA) & ~stuff_bit;
    assign last_data = (bit_cnt == 4'd7);

    // Hard sync only allowed between frames
    assign rx_idle = (state == RX_IDLE);
    assign rx_rsp  = '{valid: valid_q, data: data_q};

    // Payload path
    always_ff @(posedge clk) begin
        if (take_bit) begin
            shreg <= {shreg[6:0], bit_in};
            if (last_data) begin
                data_q <= {shreg[6:0], bit_in};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            valid_q  <= 1'b0;
            bit_cnt  <= '0;
            run_cnt  <= '0;
            last_bit <= 1'b1;
            rec_cnt  <= '0;
        end else begin
            valid_q <= 1'b0;
            if (sample) begin
                case (state)
                    RX_IDLE: begin
                        if (!bit_in) begin
                            state    <= RX_DATA;   // SOF counts toward the first run
                            last_bit <= 1'b0;
                            run_cnt  <= 3'd1;
                            bit_cnt  <= '0;
                        end
                    end
                    RX_DATA: begin
                        last_bit <= bit_in;
                        if (stuff_bit) begin
                            run_cnt <= 3'd1;       // Dropped, but it opens a new run
                        end else begin
                            run_cnt <= (bit_in == last_bit) ? run_cnt + 3'd1 : 3'd1;
                            bit_cnt <= bit_cnt + 4'd1;
                            if (last_data) begin
                                valid_q <= 1'b1;
                                rec_cnt <= '0;
                                state   <= RX_EOF;
                            end
                        end
                    end
                    RX_EOF: begin
                        // A trailing stuff bit may still come, dominant restarts the count
                        if (!bit_in) begin
                            rec_cnt <= '0;
                        end else if (rec_cnt == 3'(can_pkg::EOF_BITS - 1)) begin
                            state <= RX_IDLE;
                        end else begin
                            rec_cnt <= rec_cnt + 3'd1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

endmodule

//--- src/can_tx_framer.sv
`timescale 1ns/1ps
// CAN transmit framer sending SOF, eight stuffed data bits MSB first and EOF on can_tx
module can_tx_framer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  can_pkg::tx_req_t     tx_req,
    input  can_pkg::bit_strobe_t strobe,
    output logic                 tx_busy,
    output logic                 can_tx
);
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SOF,
        TX_DATA,
        TX_EOF
    } tx_state_e;

    tx_state_e state;
    logic pending;                 // Byte taken, SOF waits for tx_point
    can_pkg::can_byte_t shreg;     // Top bit is the next data bit
    logic [3:0] bit_idx;           // Data bits already on the wire
    logic [2:0] run_cnt;           // Equal bits in a row, stuff bits included
    logic last_bit;                // Level of the bit now on the wire
    logic [2:0] eof_cnt;
    logic data_bit;
    logic stuff_due;
    logic data_done;
    logic send_data;

    assign data_bit  = shreg[7];
    assign stuff_due = (run_cnt == 3'(can_pkg::STUFF_RUN));
    assign data_done = (bit_idx == 4'd8);
    assign send_data = strobe.tx_point & ((state == TX_SOF) | (state == TX_DATA)) &
                       ~stuff_due & ~data_done;

    // Busy from the clock after start until the last EOF bit is over
    assign tx_busy = pending | (state != TX_IDLE);

    // Payload shifter
    always_ff @(posedge clk) begin
        if (tx_req.start) begin
            shreg <= tx_req.data;
        end else if (send_data) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            pending  <= 1'b0;
            bit_idx  <= '0;
            run_cnt  <= '0;
            last_bit <= 1'b1;
            eof_cnt  <= '0;
            can_tx   <= 1'b1;            // Recessive
        end else begin
            if (tx_req.start) begin
                pending <= 1'b1;
            end
            if (strobe.tx_point) begin
                case (state)
                    TX_IDLE: begin
                        if (pending || tx_req.start) begin
                            can_tx   <= 1'b0;        // Dominant SOF opens the first run
                            last_bit <= 1'b0;
                            run_cnt  <= 3'd1;
                            bit_idx  <= '0;
                            pending  <= 1'b0;
                            state    <= TX_SOF;
                        end
                    end
                    TX_SOF, TX_DATA: begin
                        if (stuff_due) begin
                            // Complement bit, starts a new run
                            can_tx   <= ~last_bit;
                            last_bit <= ~last_bit;
                            run_cnt  <= 3'd1;
                            state    <= TX_DATA;
                        end else if (data_done) begin
                            can_tx  <= 1'b1;
                            eof_cnt <= '0;
                            state   <= TX_EOF;
                        end else begin
                            can_tx   <= data_bit;
                            last_bit <= data_bit;
                            run_cnt  <= (data_bit == last_bit) ? run_cnt + 3'd1 : 3'd1;
                            bit_idx  <= bit_idx + 4'd1;
                            state    <= TX_DATA;
                        end
                    end
                    TX_EOF: begin
                        if (eof_cnt == 3'(can_pkg::EOF_BITS - 1)) begin
                            state <= TX_IDLE;        // Seventh end bit done
                        end else begin
                            eof_cnt <= eof_cnt + 3'd1;
                        end
                    end
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

endmodule
